/* logic/fft_pkg.sv */
`default_nettype none

package fft_pkg;

    localparam int N_POINTS = 16;
    localparam int N_STAGES = 4;
    localparam int SAMPLE_W = 16;
    // sign guard on top, one fraction bit below
    localparam int INT_W    = 18;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef sample_t [N_POINTS-1:0] frame_t;

    typedef struct packed {
        logic signed [INT_W-1:0] re;
        logic signed [INT_W-1:0] im;
    } cplx_t;

    // Q16 coefficients
    typedef struct packed {
        logic signed [17:0] re;
        logic signed [17:0] im;
    } twiddle_t;

    // W16^n = cos - j sin, n = 0..7
    localparam twiddle_t TWIDDLE_ROM [N_POINTS/2] = '{
        '{ 18'sd65536,  18'sd0     },
        '{ 18'sd60547, -18'sd25079 },
        '{ 18'sd46340, -18'sd46340 },
        '{ 18'sd25079, -18'sd60547 },
        '{ 18'sd0,     -18'sd65536 },
        '{-18'sd25079, -18'sd60547 },
        '{-18'sd46340, -18'sd46340 },
        '{-18'sd60547, -18'sd25079 }
    };

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        STAGE1 = 3'd1,
        STAGE2 = 3'd2,
        STAGE3 = 3'd3,
        STAGE4 = 3'd4,
        DONE   = 3'd7
    } stage_t;

endpackage

`default_nettype wire

/* logic/sample_collector.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_collector import fft_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire sample_t fir_d,
    input  wire          fir_valid,
    output frame_t       frame,
    output logic         frame_ready
);

    // next slot to fill, wraps at 16
    logic [3:0] count;

    //////////////////////////////////////////////////////////////////////
    // serial to parallel
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count       <= '0;
            frame_ready <= 1'b0;
            frame       <= '0;
        end else begin
            // strobe once the last slot has been written
            frame_ready <= fir_valid && (count == 4'(N_POINTS - 1));
            if (fir_valid) begin
                frame[count] <= fir_d;
                count        <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/butterfly.sv */
`timescale 1ns/1ns
`default_nettype none

module butterfly import fft_pkg::*; (
    input  wire cplx_t    upper_in,
    input  wire cplx_t    lower_in,
    input  wire twiddle_t twiddle,
    output cplx_t         upper_out,
    output cplx_t         lower_out
);

    logic signed [INT_W-1:0]   diff_re;
    logic signed [INT_W-1:0]   diff_im;
    logic signed [2*INT_W-1:0] prod_rr;
    logic signed [2*INT_W-1:0] prod_ii;
    logic signed [2*INT_W-1:0] prod_ri;
    logic signed [2*INT_W-1:0] prod_ir;

    assign diff_re = upper_in.re - lower_in.re;
    assign diff_im = upper_in.im - lower_in.im;

    // (dr + j di)(wr + j wi)
    assign prod_rr = diff_re * twiddle.re;
    assign prod_ii = -(diff_im * twiddle.im);
    assign prod_ri = diff_re * twiddle.im;
    assign prod_ir = diff_im * twiddle.re;

    assign upper_out = '{
        re: upper_in.re + lower_in.re,
        im: upper_in.im + lower_in.im
    };

    // drop the Q16 fraction, keep 18 bits of each product
    assign lower_out = '{
        re: prod_rr[33:16] + prod_ii[33:16],
        im: prod_ri[33:16] + prod_ir[33:16]
    };

endmodule

`default_nettype wire

/* logic/fft_core.sv */
`timescale 1ns/1ns
`default_nettype none

module fft_core import fft_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire frame_t frame,
    input  wire         frame_ready,
    output frame_t      spectrum_re,
    output frame_t      spectrum_im,
    output logic        result_ready
);

    stage_t     state;
    // bank0 takes the input and holds the final result
    cplx_t      bank0 [N_POINTS];
    cplx_t      bank1 [N_POINTS];
    logic       src_sel;
    logic [3:0] idx_a [N_POINTS/2];
    logic [3:0] idx_b [N_POINTS/2];
    logic [2:0] tw_idx [N_POINTS/2];
    cplx_t      bf_a [N_POINTS/2];
    cplx_t      bf_b [N_POINTS/2];
    cplx_t      bf_up [N_POINTS/2];
    cplx_t      bf_lo [N_POINTS/2];

    //////////////////////////////////////////////////////////////////////
    // stage sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (frame_ready) state <= STAGE1;
                STAGE1:  state <= STAGE2;
                STAGE2:  state <= STAGE3;
                STAGE3:  state <= STAGE4;
                STAGE4:  state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    assign result_ready = (state == DONE);
    // odd stages read bank0, even stages read bank1
    assign src_sel = (state == STAGE2) || (state == STAGE4);

    // pairing: i with i + span, span = 8, 4, 2, 1
    always_comb begin
        int lvl;
        int span;
        int ofs;
        lvl  = 0;
        span = 1;
        ofs  = 0;
        for (int k = 0; k < N_POINTS/2; k++) begin
            idx_a[k]  = '0;
            idx_b[k]  = '0;
            tw_idx[k] = '0;
        end
        if (state inside {STAGE1, STAGE2, STAGE3, STAGE4}) begin
            lvl  = N_STAGES - int'(state);
            span = 1 << lvl;
            for (int k = 0; k < N_POINTS/2; k++) begin
                ofs       = k % span;
                idx_a[k]  = 4'(((k >> lvl) << (lvl + 1)) + ofs);
                idx_b[k]  = 4'(((k >> lvl) << (lvl + 1)) + ofs + span);
                tw_idx[k] = 3'(ofs << (N_STAGES - 1 - lvl));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // butterfly array
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < N_POINTS/2; k++) begin : g_bf
        assign bf_a[k] = src_sel ? bank1[idx_a[k]] : bank0[idx_a[k]];
        assign bf_b[k] = src_sel ? bank1[idx_b[k]] : bank0[idx_b[k]];

        butterfly u_bf (
            .upper_in  (bf_a[k]),
            .lower_in  (bf_b[k]),
            .twiddle   (TWIDDLE_ROM[tw_idx[k]]),
            .upper_out (bf_up[k]),
            .lower_out (bf_lo[k])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < N_POINTS; p++) begin
                bank0[p] <= '0;
                bank1[p] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    // sample x2, imaginary part zero
                    if (frame_ready) begin
                        for (int p = 0; p < N_POINTS; p++) begin
                            bank0[p].re <= {frame[p][SAMPLE_W-1], frame[p], 1'b0};
                            bank0[p].im <= '0;
                        end
                    end
                end
                STAGE1, STAGE3: begin
                    for (int k = 0; k < N_POINTS/2; k++) begin
                        bank1[idx_a[k]] <= bf_up[k];
                        bank1[idx_b[k]] <= bf_lo[k];
                    end
                end
                STAGE2, STAGE4: begin
                    for (int k = 0; k < N_POINTS/2; k++) begin
                        bank0[idx_a[k]] <= bf_up[k];
                        bank0[idx_b[k]] <= bf_lo[k];
                    end
                end
                default: ;
            endcase
        end
    end

    // bin b sits at position bitreverse(b)
    always_comb begin
        logic [3:0] pos;
        for (int b = 0; b < N_POINTS; b++) begin
            pos = {b[0], b[1], b[2], b[3]};
            spectrum_re[b] = bank0[pos].re[SAMPLE_W:1];
            spectrum_im[b] = bank0[pos].im[SAMPLE_W:1];
        end
    end

endmodule

`default_nettype wire

/* logic/spectrum_output.sv */
`timescale 1ns/1ns
`default_nettype none

module spectrum_output import fft_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire frame_t spectrum_re,
    input  wire frame_t spectrum_im,
    input  wire         result_ready,
    input  wire         fir_valid,
    output frame_t      fft_d,
    output logic        fft_valid,
    output logic        done
);

    // 0 = real frame next, 1 = imag frame next
    logic phase_im;
    logic fir_shadow;
    logic fft_shadow;
    // input went quiet, waiting for the last results
    logic drain;

    //////////////////////////////////////////////////////////////////////
    // real then imag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_im  <= 1'b0;
            fft_valid <= 1'b0;
            fft_d     <= '0;
        end else if (result_ready || phase_im) begin
            fft_d     <= phase_im ? spectrum_im : spectrum_re;
            fft_valid <= 1'b1;
            phase_im  <= ~phase_im;
        end else begin
            fft_valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // end of stream
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_shadow <= 1'b0;
            fft_shadow <= 1'b0;
            drain      <= 1'b0;
            done       <= 1'b0;
        end else begin
            fir_shadow <= fir_valid;
            fft_shadow <= fft_valid;
            done       <= 1'b0;
            // falling edge of fir_valid arms
            if (fir_shadow && !fir_valid) begin
                drain <= 1'b1;
            end
            // falling edge of fft_valid fires and disarms
            if (drain && fft_shadow && !fft_valid) begin
                done  <= 1'b1;
                drain <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/fft16.sv */
`timescale 1ns/1ns
`default_nettype none

module fft16 import fft_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire sample_t fir_d,
    input  wire          fir_valid,
    output logic         fft_valid,
    output logic         done,
    output frame_t       fft_d
);

    frame_t frame;
    logic   frame_ready;
    frame_t spectrum_re;
    frame_t spectrum_im;
    logic   result_ready;

    sample_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    fft_core u_core (
        .clk          (clk),
        .rst          (rst),
        .frame        (frame),
        .frame_ready  (frame_ready),
        .spectrum_re  (spectrum_re),
        .spectrum_im  (spectrum_im),
        .result_ready (result_ready)
    );

    spectrum_output u_output (
        .clk          (clk),
        .rst          (rst),
        .spectrum_re  (spectrum_re),
        .spectrum_im  (spectrum_im),
        .result_ready (result_ready),
        .fir_valid    (fir_valid),
        .fft_d        (fft_d),
        .fft_valid    (fft_valid),
        .done         (done)
    );

endmodule

`default_nettype wire

/* tb/fft16_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module fft16_assert import fft_pkg::*; (
    input wire clk,
    input wire rst,
    input wire fir_valid,
    input wire fft_valid,
    input wire done,
    input wire frame_ready
);

    // set once the collector has handed over its first frame
    logic seen_frame;
    // input arrived since the last done pulse
    logic fed;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_frame <= 1'b0;
        end else if (frame_ready) begin
            seen_frame <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fed <= 1'b0;
        end else if (fir_valid) begin
            fed <= 1'b1;
        end else if (done) begin
            fed <= 1'b0;
        end
    end

    // a real and an imag beat, never a third
    valid_burst: assert property (@(posedge clk) disable iff (rst)
        (fft_valid && $past(fft_valid)) |-> !$past(fft_valid, 2))
        else $error("fft_valid stayed high for more than two cycles");

    // one done per quiet period, so also never two cycles long
    done_once: assert property (@(posedge clk) disable iff (rst)
        done |-> fed)
        else $error("done pulsed again without new input in between");

    done_alone: assert property (@(posedge clk) disable iff (rst)
        done |-> !fft_valid)
        else $error("done and fft_valid high together");

    quiet_start: assert property (@(posedge clk) disable iff (rst)
        !seen_frame |-> (!fft_valid && !done))
        else $error("output activity before the first frame completed");

endmodule

bind fft16 fft16_assert u_fft16_assert (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fft_valid   (fft_valid),
    .done        (done),
    .frame_ready (frame_ready)
);

`default_nettype wire

/* tb/fft16_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fft16_tb import fft_pkg::*; ();

    // each record holds a gap word, the samples, the real bins and the imag bins
    localparam int          REC_W        = 1 + 3*N_POINTS;
    localparam int          N_FRAMES     = 6;
    localparam int          DONE_TIMEOUT = 60;
    localparam logic [15:0] END_MARK     = 16'he0f5;

    logic    clk;
    logic    rst;
    sample_t fir_d;
    logic    fir_valid;
    logic    fft_valid;
    logic    done;
    frame_t  fft_d;

    logic [15:0] stim [REC_W*N_FRAMES + 1];
    int          errors     = 0;
    int          timeouts   = 0;
    int          frames_in  = 0;
    int          frames_out = 0;
    int          done_count = 0;
    int          groups     = 0;

    fft16 u_fft16 (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .done      (done),
        .fft_d     (fft_d)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERR t=%0t %s got 0x%h expected 0x%h", $time, name, got, expected);
        end
    endtask

    task automatic compare_frame(input int f, input frame_t re, input frame_t im);
        int base;
        base = f*REC_W + 1 + N_POINTS;
        for (int b = 0; b < N_POINTS; b++) begin
            check_value($sformatf("fft_d[%0d] real, frame %0d", b, f), re[b], stim[base + b]);
            check_value($sformatf("fft_d[%0d] imag, frame %0d", b, f), im[b],
                        stim[base + N_POINTS + b]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // done must stay low in any cycle with fir_valid high
    task automatic next_cycle();
        @(negedge clk);
        if (fir_valid) begin
            check_value("done", 16'(done), 16'h0);
        end
    endtask

    task automatic drive_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
            fir_valid = 1'b0;
            fir_d     = '0;
        end
    endtask

    task automatic drive_frame(input int f);
        for (int n = 0; n < N_POINTS; n++) begin
            next_cycle();
            fir_valid = 1'b1;
            fir_d     = sample_t'(stim[f*REC_W + 1 + n]);
        end
        frames_in++;
    endtask

    task automatic wait_done();
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < DONE_TIMEOUT) begin
            next_cycle();
            fir_valid = 1'b0;
            fir_d     = '0;
            seen      = done;
            waited++;
        end
        if (!seen) begin
            timeouts++;
            $display("no done pulse within %0d cycles after input frame %0d",
                     DONE_TIMEOUT, frames_in - 1);
        end else begin
            // every imag frame of the group is out before done
            check_value("frames out at done", 16'(frames_out), 16'(frames_in));
        end
    endtask

    // output monitor expecting a real frame and then an imag frame
    initial begin
        frame_t real_frame;
        logic   phase_im;
        real_frame = '0;
        phase_im   = 1'b0;
        forever begin
            @(negedge clk);
            if (done) begin
                done_count++;
            end
            if (phase_im) begin
                phase_im = 1'b0;
                if (!fft_valid) begin
                    errors++;
                    $display("imaginary frame missing after real frame at t=%0t", $time);
                end else if (frames_out < N_FRAMES) begin
                    compare_frame(frames_out, real_frame, fft_d);
                end
                frames_out++;
            end else if (fft_valid) begin
                real_frame = fft_d;
                phase_im   = 1'b1;
                if (frames_out >= frames_in) begin
                    errors++;
                    $display("output frame with no input frame behind it at t=%0t", $time);
                end
            end
        end
    end

    initial begin
        int   f;
        int   gap;
        logic stim_ok;
        rst       = 1'b1;
        fir_valid = 1'b0;
        fir_d     = '0;
        stim[REC_W*N_FRAMES] = '0;
        $readmemh("tb/fft16_stim.txt", stim);
        stim_ok = (stim[REC_W*N_FRAMES] == END_MARK);

        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value("fft_valid", 16'(fft_valid), 16'h0);
            check_value("done", 16'(done), 16'h0);
        end
        rst = 1'b0;

        if (!stim_ok) begin
            errors++;
            $display("stimulus file tb/fft16_stim.txt is missing or incomplete");
        end

        // a nonzero gap starts a new group
        f = 0;
        while (stim_ok && f < N_FRAMES && timeouts == 0) begin
            gap = int'(stim[f*REC_W]);
            if (gap != 0 || f == 0) begin
                if (f != 0) begin
                    wait_done();
                end
                groups++;
                drive_idle(gap);
            end
            if (timeouts == 0) begin
                drive_frame(f);
            end
            f++;
        end
        if (stim_ok && timeouts == 0) begin
            wait_done();
            // a few quiet cycles so a late or repeated done is counted
            drive_idle(4);
        end
        if (timeouts == 0) begin
            check_value("done pulses", 16'(done_count), 16'(groups));
        end

        $display("errors=%0d timeouts=%0d frames_in=%0d frames_out=%0d done_pulses=%0d",
                 errors, timeouts, frames_in, frames_out, done_count);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/fft_pkg.sv
logic/sample_collector.sv
logic/butterfly.sv
logic/fft_core.sv
logic/spectrum_output.sv
logic/fft16.sv
tb/fft16_assert.sv
tb/fft16_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fft16 testbench with Verilator, from the project root

cd "$(dirname "$0")" || { echo "cannot enter project root"; exit 1; }

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module fft16_tb -f filelist.f -o fft16_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fft16_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
exit 1

/* tb/fft16_stim.txt */
// per frame: idle gap, 16 input samples, 16 expected real bins, 16 expected imag bins
// 16-bit hex words, bins in natural order; the last word is the end marker e0f5
0002
7fff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0014
0000 0000 0000 0000 3039 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
3039 0000 cfc7 0000 3039 0000 cfc7 0000 3039 0000 cfc7 0000 3039 0000 cfc7 0000
0000 cfc7 0000 3039 0000 cfc7 0000 3039 0000 cfc7 0000 3039 0000 cfc7 0000 3039
0000
03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8
3e80 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000
8000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000
0000 0000 2000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
2000 16a0 0000 e95f e000 e95f 0000 16a0 2000 16a0 0000 e95f e000 e95f 0000 16a0
0000 e95f e000 e95f 0000 16a0 2000 16a0 0000 e95f e000 e95f 0000 16a0 2000 16a0
0019
05dc fa24 05dc fa24 05dc fa24 05dc fa24 05dc fa24 05dc fa24 05dc fa24 05dc fa24
0000 0000 0000 0000 0000 0000 0000 0000 5dc0 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
e0f5
